// File: all.f
+incdir+rtl
rtl/fp_pkg.sv
rtl/fp_sum_if.sv
rtl/float_point_classify.sv
rtl/float_point_adder.sv
rtl/fp_normalize_round.sv
rtl/fp_add_top.sv
verif/fp_tb_clock.sv
verif/fp_add_asserts.sv
verif/fp_add_tb.sv

// File: Makefile
VERILATOR  ?= verilator
FILELIST   ?= all.f
TB_TOP     ?= fp_add_tb
BUILD_DIR  ?= obj_dir
LINT_FLAGS ?= -Wall
SIM_FLAGS  ?= -Wno-fatal
PASS_TEXT  ?= All tests passed!

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing $(LINT_FLAGS) --top-module $(TB_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary --timing --assert $(SIM_FLAGS) --top-module $(TB_TOP) \
		-f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TB_TOP))"; echo "$$out"; \
		echo "$$out" | grep -qF "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

// File: verif/fp_add_tb.sv
`timescale 1ns/1ps

module fp_add_tb;
    import fp_pkg::*;

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 5;
    localparam int IDLE_CYCLES  = 8;
    localparam int WAIT_LIMIT   = 12;

    typedef struct packed
    {
        op_mode_t       op;
        round_mode_t    rm;
        logic [31:0]    a;
        logic [31:0]    b;
        logic [31:0]    expected;
    } test_entry_t;

    logic           clk_in;
    logic           reset_in;
    op_mode_t       op_mode;
    round_mode_t    round_mode;
    logic           operand_0_valid;
    logic           operand_0_sign;
    logic [7:0]     operand_0_exponent;
    logic [22:0]    operand_0_fraction;
    logic           operand_1_valid;
    logic           operand_1_sign;
    logic [7:0]     operand_1_exponent;
    logic [22:0]    operand_1_fraction;
    logic           issue_ack;
    logic           product_valid;
    logic           product_sign;
    logic [7:0]     product_exponent;
    logic [22:0]    product_fraction;

    test_entry_t    test_table[$];
    int             error_count;
    int             fail_tests;
    int             test_count;
    logic [31:0]    rand_state;

    fp_tb_clock #(.PERIOD_NS(CLK_PERIOD)) u_clock (.clk(clk_in));

    fp_add_top uut
    (
        .clk_in             (clk_in),
        .reset_in           (reset_in),
        .op_mode            (op_mode),
        .round_mode         (round_mode),
        .operand_0_valid    (operand_0_valid),
        .operand_0_sign     (operand_0_sign),
        .operand_0_exponent (operand_0_exponent),
        .operand_0_fraction (operand_0_fraction),
        .operand_1_valid    (operand_1_valid),
        .operand_1_sign     (operand_1_sign),
        .operand_1_exponent (operand_1_exponent),
        .operand_1_fraction (operand_1_fraction),
        .issue_ack          (issue_ack),
        .product_valid      (product_valid),
        .product_sign       (product_sign),
        .product_exponent   (product_exponent),
        .product_fraction   (product_fraction)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected)
        begin
            $display("ERR %0t ns: %s is %h, expected %h", $time, what, got, expected);
            error_count++;
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        test_count++;
        if (error_count == errors_before)
        begin
            $display("test %s: ok", name);
        end
        else
        begin
            $display("test %s: mismatch", name);
            fail_tests++;
        end
    endtask

    task automatic add_entry(input op_mode_t op, input round_mode_t rm, input logic [31:0] a,
                             input logic [31:0] b, input logic [31:0] expected);
        test_entry_t entry;
        entry.op       = op;
        entry.rm       = rm;
        entry.a        = a;
        entry.b        = b;
        entry.expected = expected;
        test_table.push_back(entry);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Operands and results as IEEE single precision bit patterns.
    ////////////////////////////////////////////////////////////////////////////

    task automatic load_table();
        add_entry(op_add, round_chop, 32'h3F800000, 32'h3F800000, 32'h40000000);
        add_entry(op_add, round_chop, 32'h3FC00000, 32'h3FC00000, 32'h40400000);
        add_entry(op_sub, round_chop, 32'h3F800000, 32'h3F400000, 32'h3E800000);
        add_entry(op_add, round_chop, 32'h3F800000, 32'h40000000, 32'h40400000);
        add_entry(op_sub, round_nearest_even, 32'h3F800000, 32'h40000000, 32'hBF800000);
        add_entry(op_add, round_nearest_even, 32'hBFC00000, 32'h3F000000, 32'hBF800000);
        add_entry(op_sub, round_nearest_even, 32'hC0200000, 32'h3FA00000, 32'hC0700000);
        // Half an LSB on an even and on an odd fraction.
        add_entry(op_add, round_chop, 32'h3F800000, 32'h33800000, 32'h3F800000);
        add_entry(op_add, round_nearest_even, 32'h3F800000, 32'h33800000, 32'h3F800000);
        add_entry(op_add, round_chop, 32'h3F800001, 32'h33800000, 32'h3F800001);
        add_entry(op_add, round_nearest_even, 32'h3F800001, 32'h33800000, 32'h3F800002);
        add_entry(op_add, round_chop, 32'h3F800000, 32'h33C00000, 32'h3F800000);
        add_entry(op_add, round_nearest_even, 32'h3F800000, 32'h33C00000, 32'h3F800001);
        add_entry(op_add, round_chop, 32'h3FFFFFFF, 32'h33800000, 32'h3FFFFFFF);
        add_entry(op_add, round_nearest_even, 32'h3FFFFFFF, 32'h33800000, 32'h40000000);
        add_entry(op_add, round_chop, 32'h40490FDB, 32'h3F800000, 32'h408487ED);
        add_entry(op_add, round_nearest_even, 32'h40490FDB, 32'h3F800000, 32'h408487EE);
        add_entry(op_sub, round_chop, 32'h3F800000, 32'h0D800000, 32'h3F7FFFFF);
        add_entry(op_sub, round_nearest_even, 32'h3F800000, 32'h0D800000, 32'h3F800000);
        add_entry(op_add, round_nearest_even, 32'hFF800001, 32'h3F800000, 32'h7FC00000);
        add_entry(op_add, round_chop, 32'h3F800000, 32'h7FC00000, 32'h7FC00000);
        add_entry(op_sub, round_nearest_even, 32'h7F800000, 32'h7F800000, 32'h7FC00000);
        add_entry(op_add, round_chop, 32'h7F800000, 32'h3F800000, 32'h7F800000);
        add_entry(op_sub, round_nearest_even, 32'h3F800000, 32'h7F800000, 32'hFF800000);
        add_entry(op_add, round_chop, 32'hFF800000, 32'h7F800000, 32'h7FC00000);
        add_entry(op_sub, round_chop, 32'h40490FDB, 32'h40490FDB, 32'h00000000);
        add_entry(op_sub, round_nearest_even, 32'hC0490FDB, 32'hC0490FDB, 32'h00000000);
        add_entry(op_add, round_chop, 32'h80000000, 32'h80000000, 32'h80000000);
        add_entry(op_sub, round_nearest_even, 32'h80000000, 32'h00000000, 32'h80000000);
        add_entry(op_add, round_nearest_even, 32'h00400000, 32'h3F800000, 32'h3F800000);
        add_entry(op_add, round_chop, 32'h00400000, 32'h00400000, 32'h00000000);
        add_entry(op_add, round_nearest_even, 32'h7F7FFFFF, 32'h7F7FFFFF, 32'h7F800000);
        add_entry(op_sub, round_chop, 32'h00C00000, 32'h00800000, 32'h00000000);
    endtask

    task automatic check_reset();
        int errors_before;
        errors_before = error_count;
        check_value("issue_ack after reset", 32'(issue_ack), 32'h0);
        check_value("product_valid after reset", 32'(product_valid), 32'h0);
        check_value("result after reset",
                    {product_sign, product_exponent, product_fraction}, 32'h0);
        report_test("reset", errors_before);
    endtask

    // One valid alone must not start an operation either.
    task automatic check_idle();
        int errors_before;
        int results;
        errors_before = error_count;
        results = 0;
        for (int i = 0; i < IDLE_CYCLES; i++)
        begin
            operand_0_valid = (i >= IDLE_CYCLES / 2);
            @(negedge clk_in);
            if (product_valid)
                results++;
        end
        operand_0_valid = 1'b0;
        check_value("results with valids low", 32'(results), 32'h0);
        check_value("issue_ack while waiting", 32'(issue_ack), 32'h1);
        report_test("idle", errors_before);
    endtask

    task automatic run_entry(input int index);
        test_entry_t entry;
        int          errors_before;
        int          gap;
        int          edges;
        entry = test_table[index];
        errors_before = error_count;
        rand_state = xorshift32(rand_state);
        gap = int'(rand_state[1:0]);
        op_mode = entry.op;
        round_mode = entry.rm;
        {operand_0_sign, operand_0_exponent, operand_0_fraction} = entry.a;
        {operand_1_sign, operand_1_exponent, operand_1_fraction} = entry.b;
        repeat (gap) @(negedge clk_in);
        operand_0_valid = 1'b1;
        operand_1_valid = 1'b1;
        edges = 0;
        while (!issue_ack && edges < WAIT_LIMIT)
        begin
            @(negedge clk_in);
            edges++;
        end
        if (!issue_ack)
        begin
            $display("test %0d: issue_ack never rose, the operands were not accepted", index);
            error_count++;
        end
        else
        begin
            @(negedge clk_in);      // The accept edge has passed.
            operand_0_valid = 1'b0;
            operand_1_valid = 1'b0;
            edges = 0;
            while (!product_valid && edges < WAIT_LIMIT)
            begin
                @(negedge clk_in);
                edges++;
            end
            if (!product_valid)
            begin
                $display("test %0d: product_valid never rose after the accept", index);
                error_count++;
            end
            else
            begin
                check_value("edges from accept to result", 32'(edges), 32'd3);
                check_value($sformatf("%h %s %h", entry.a, entry.op.name(), entry.b),
                            {product_sign, product_exponent, product_fraction},
                            entry.expected);
            end
        end
        operand_0_valid = 1'b0;
        operand_1_valid = 1'b0;
        report_test($sformatf("%0d (%s %s)", index, entry.op.name(), entry.rm.name()),
                    errors_before);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence and watchdog.
    ////////////////////////////////////////////////////////////////////////////

    initial
    begin
        error_count = 0;
        fail_tests = 0;
        test_count = 0;
        rand_state = 32'h68fcfe43;
        reset_in = 1'b1;
        op_mode = op_add;
        round_mode = round_chop;
        operand_0_valid = 1'b0;
        operand_1_valid = 1'b0;
        {operand_0_sign, operand_0_exponent, operand_0_fraction} = '0;
        {operand_1_sign, operand_1_exponent, operand_1_fraction} = '0;
        load_table();

        repeat (RESET_CYCLES) @(posedge clk_in);
        @(negedge clk_in);
        reset_in = 1'b0;
        check_reset();
        check_idle();
        for (int i = 0; i < test_table.size(); i++)
            run_entry(i);

        $display("%0d tests run, %0d failed, %0d errors", test_count, fail_tests, error_count);
        if (error_count == 0)
        begin
            $display("All tests passed!");
        end
        else
        begin
            $display("Test failures found");
        end
        $finish;
    end

    initial
    begin
        longint limit_ns;
        #1;     // Lets the table load first.
        limit_ns = longint'(test_table.size() * 10 + RESET_CYCLES + IDLE_CYCLES) * CLK_PERIOD;
        #(limit_ns);
        $display("Timeout: the run did not complete within %0d ns", limit_ns);
        $display("Test failures found");
        $finish;
    end

endmodule

// File: verif/fp_add_asserts.sv
`timescale 1ns/1ps

module fp_add_asserts
(
    input logic                 clk_in,
    input logic                 reset_in,
    input logic                 operand_0_valid,
    input logic                 operand_1_valid,
    input logic                 issue_ack,
    input logic                 product_valid,
    input fp_pkg::ctrl_state_t  ctrl_state
);
    import fp_pkg::*;

    logic accept;

    assign accept = issue_ack && operand_0_valid && operand_1_valid;

    single_cycle_result: assert property (@(posedge clk_in) disable iff (reset_in)
        product_valid |=> !product_valid)
        else $error("product_valid was high for two cycles in a row");

    // The core leaves the accept state on the accept edge.
    ack_drops_after_accept: assert property (@(posedge clk_in) disable iff (reset_in)
        accept |=> !issue_ack)
        else $error("issue_ack stayed high after an accept");

    // Compute and post-shift last one cycle each before the core is ready again.
    state_sequence: assert property (@(posedge clk_in) disable iff (reset_in)
        ctrl_state == state_compute |=> ctrl_state == state_post_shift ##1
        ctrl_state == state_pre_shift)
        else $error("core state left the compute sequence");

    // The result register updates on the third edge, so it is seen at the fourth.
    result_latency: assert property (@(posedge clk_in) disable iff (reset_in)
        product_valid == $past(accept, 4))
        else $error("product_valid does not follow an accept by three edges");

endmodule

bind fp_add_top fp_add_asserts u_asserts
(
    .clk_in          (clk_in),
    .reset_in        (reset_in),
    .operand_0_valid (operand_0_valid),
    .operand_1_valid (operand_1_valid),
    .issue_ack       (issue_ack),
    .product_valid   (product_valid),
    .ctrl_state      (u_adder.ctrl_state)
);

// File: verif/fp_tb_clock.sv
`timescale 1ns/1ps

module fp_tb_clock
#(
    parameter int PERIOD_NS = 100
)
(
    output logic clk
);

    initial
    begin
        clk = 1'b0;
        forever
            #(PERIOD_NS / 2) clk = ~clk;    // Rising edges at odd half periods.
    end

endmodule

// File: rtl/fp_add_top.sv
`timescale 1ns/1ps
`include "fp_defines.svh"

module fp_add_top
(
    input  logic                        clk_in,
    input  logic                        reset_in,
    input  fp_pkg::op_mode_t            op_mode,
    input  fp_pkg::round_mode_t         round_mode,
    input  logic                        operand_0_valid,
    input  logic                        operand_0_sign,
    input  logic [`FP_EXP_WIDTH-1:0]    operand_0_exponent,
    input  logic [`FP_FRAC_WIDTH-1:0]   operand_0_fraction,
    input  logic                        operand_1_valid,
    input  logic                        operand_1_sign,
    input  logic [`FP_EXP_WIDTH-1:0]    operand_1_exponent,
    input  logic [`FP_FRAC_WIDTH-1:0]   operand_1_fraction,
    output logic                        issue_ack,
    output logic                        product_valid,
    output logic                        product_sign,
    output logic [`FP_EXP_WIDTH-1:0]    product_exponent,
    output logic [`FP_FRAC_WIDTH-1:0]   product_fraction
);
    import fp_pkg::*;

    fp_class_t operand_0_class;
    fp_class_t operand_1_class;

    fp_sum_if sum_bus ();

    float_point_classify u_classify_0
    (
        .exponent (operand_0_exponent),
        .fraction (operand_0_fraction),
        .fp_class (operand_0_class)
    );

    float_point_classify u_classify_1
    (
        .exponent (operand_1_exponent),
        .fraction (operand_1_fraction),
        .fp_class (operand_1_class)
    );

    float_point_adder u_adder
    (
        .clk_in             (clk_in),
        .reset_in           (reset_in),
        .op_mode            (op_mode),
        .round_mode         (round_mode),
        .operand_0_valid    (operand_0_valid),
        .operand_0_sign     (operand_0_sign),
        .operand_0_exponent (operand_0_exponent),
        .operand_0_fraction (operand_0_fraction),
        .operand_0_class    (operand_0_class),
        .operand_1_valid    (operand_1_valid),
        .operand_1_sign     (operand_1_sign),
        .operand_1_exponent (operand_1_exponent),
        .operand_1_fraction (operand_1_fraction),
        .operand_1_class    (operand_1_class),
        .issue_ack          (issue_ack),
        .sum                (sum_bus)
    );

    fp_normalize_round u_normalize
    (
        .clk_in           (clk_in),
        .reset_in         (reset_in),
        .sum              (sum_bus),
        .product_valid    (product_valid),
        .product_sign     (product_sign),
        .product_exponent (product_exponent),
        .product_fraction (product_fraction)
    );

endmodule

// File: rtl/fp_normalize_round.sv
`timescale 1ns/1ps
`include "fp_defines.svh"

module fp_normalize_round
(
    input  logic                        clk_in,
    input  logic                        reset_in,
    fp_sum_if.norm                      sum,
    output logic                        product_valid,
    output logic                        product_sign,
    output logic [`FP_EXP_WIDTH-1:0]    product_exponent,
    output logic [`FP_FRAC_WIDTH-1:0]   product_fraction
);
    import fp_pkg::*;

    localparam int EXT_WIDTH = `FP_FRAC_WIDTH + `FP_GUARD_BITS + 2;
    localparam int LZC_WIDTH = $clog2(EXT_WIDTH);
    localparam int EXP_MAX   = 2 * `FP_EXP_BIAS + 1;   // The all-ones exponent.

    logic [LZC_WIDTH-1:0]       lead_zeros;
    logic [EXT_WIDTH-1:0]       norm_mag;
    int                         norm_exp;
    int                         final_exp;
    logic                       round_up;
    logic [`FP_FRAC_WIDTH+1:0]  rounded;
    logic                       res_sign;
    logic [`FP_EXP_WIDTH-1:0]   res_exp;
    logic [`FP_FRAC_WIDTH-1:0]  res_frac;

    function automatic logic [LZC_WIDTH-1:0] count_leading_zeros
    (
        input logic [EXT_WIDTH-2:0] value
    );
        logic [LZC_WIDTH-1:0] count;
        logic                 found;
        count = '0;
        found = 1'b0;
        for (int i = EXT_WIDTH - 2; i >= 0; i--)
        begin
            found = found | value[i];
            if (!found)
                count = count + 1'b1;
        end
        return count;
    endfunction

    always_comb
    begin
        lead_zeros = count_leading_zeros(sum.sum_magnitude[EXT_WIDTH-2:0]);
        if (sum.sum_magnitude[EXT_WIDTH-1])
        begin
            norm_mag = {1'b0, sum.sum_magnitude[EXT_WIDTH-1:2], |sum.sum_magnitude[1:0]};
            norm_exp = int'(sum.sum_exponent) + 1;
        end
        else
        begin
            norm_mag = sum.sum_magnitude << lead_zeros;
            norm_exp = int'(sum.sum_exponent) - int'(lead_zeros);
        end

        // Nearest-even rounds up past the halfway point, or on a tie with an odd LSB.
        round_up  = (sum.round_mode == round_nearest_even) && norm_mag[`FP_GUARD_BITS-1] &&
                    ((|norm_mag[`FP_GUARD_BITS-2:0]) || norm_mag[`FP_GUARD_BITS]);
        rounded   = {1'b0, norm_mag[EXT_WIDTH-2:`FP_GUARD_BITS]} + round_up;
        final_exp = norm_exp + int'(rounded[`FP_FRAC_WIDTH+1]);

        res_sign = sum.sum_sign;
        res_exp  = '0;
        res_frac = '0;
        case (sum.special)
            class_nan:
            begin
                res_sign = 1'b0;
                res_exp  = '1;
                res_frac = {1'b1, {(`FP_FRAC_WIDTH-1){1'b0}}};
            end
            class_inf: res_exp = '1;
            class_normal:
            begin
                if (sum.sum_magnitude == '0)
                    res_exp = '0;                   // Signed zero.
                else if (final_exp >= EXP_MAX)
                    res_exp = '1;
                else if (final_exp > 0)
                begin
                    res_exp  = final_exp[`FP_EXP_WIDTH-1:0];
                    res_frac = rounded[`FP_FRAC_WIDTH-1:0];   // A rounding carry leaves zeros.
                end
            end
            default: res_exp = '0;
        endcase
    end

    always_ff @(posedge clk_in)
    begin
        if (reset_in)
        begin
            product_valid    <= 1'b0;
            product_sign     <= 1'b0;
            product_exponent <= '0;
            product_fraction <= '0;
        end
        else
        begin
            product_valid <= sum.sum_valid;
            if (sum.sum_valid)
            begin
                product_sign     <= res_sign;
                product_exponent <= res_exp;
                product_fraction <= res_frac;
            end
        end
    end

endmodule

// File: rtl/float_point_adder.sv
`timescale 1ns/1ps
`include "fp_defines.svh"

module float_point_adder
(
    input  logic                        clk_in,
    input  logic                        reset_in,
    input  fp_pkg::op_mode_t            op_mode,
    input  fp_pkg::round_mode_t         round_mode,
    input  logic                        operand_0_valid,
    input  logic                        operand_0_sign,
    input  logic [`FP_EXP_WIDTH-1:0]    operand_0_exponent,
    input  logic [`FP_FRAC_WIDTH-1:0]   operand_0_fraction,
    input  fp_pkg::fp_class_t           operand_0_class,
    input  logic                        operand_1_valid,
    input  logic                        operand_1_sign,
    input  logic [`FP_EXP_WIDTH-1:0]    operand_1_exponent,
    input  logic [`FP_FRAC_WIDTH-1:0]   operand_1_fraction,
    input  fp_pkg::fp_class_t           operand_1_class,
    output logic                        issue_ack,
    fp_sum_if.core                      sum
);
    import fp_pkg::*;

    localparam int EXT_WIDTH = `FP_FRAC_WIDTH + `FP_GUARD_BITS + 2;

    ctrl_state_t                ctrl_state;
    logic                       accept;
    logic [`FP_EXP_WIDTH:0]     exp_diff;
    logic                       op0_larger;
    logic [`FP_EXP_WIDTH-1:0]   shift_len_next;

    logic [EXT_WIDTH-1:0]       mag_0_buf;
    logic [EXT_WIDTH-1:0]       mag_1_buf;
    logic                       sign_0_buf;
    logic                       sign_1_buf;     // Already flipped for a subtract.
    logic                       eff_sub_buf;
    logic                       op0_larger_buf;
    fp_class_t                  class_0_buf;
    fp_class_t                  class_1_buf;
    round_mode_t                round_mode_buf;
    logic [`FP_EXP_WIDTH-1:0]   exponent_buf;
    logic [`FP_EXP_WIDTH-1:0]   shift_len_buf;

    logic [EXT_WIDTH-1:0]       big_mag;
    logic [EXT_WIDTH-1:0]       small_mag;
    logic                       big_sign;
    logic                       small_sign;
    logic [EXT_WIDTH-1:0]       aligned_mag;
    logic [EXT_WIDTH-1:0]       result_mag;
    logic                       result_sign;
    logic [EXT_WIDTH-1:0]       sum_mag_buf;
    logic                       sum_sign_buf;

    // Zeros, infinities and NaNs enter the datapath with no magnitude.
    function automatic logic [EXT_WIDTH-1:0] extend_magnitude
    (
        input fp_class_t                cls,
        input logic [`FP_FRAC_WIDTH-1:0] frac
    );
        logic [EXT_WIDTH-1:0] mag;
        mag = '0;
        if (cls == class_normal)
            mag = {2'b01, frac, {`FP_GUARD_BITS{1'b0}}};
        return mag;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Accept stage.
    ////////////////////////////////////////////////////////////////////////////

    assign issue_ack      = (ctrl_state == state_pre_shift);
    assign accept         = issue_ack && operand_0_valid && operand_1_valid;
    assign exp_diff       = {1'b0, operand_0_exponent} - {1'b0, operand_1_exponent};
    assign op0_larger     = ~exp_diff[`FP_EXP_WIDTH];
    assign shift_len_next = op0_larger ? exp_diff[`FP_EXP_WIDTH-1:0]
                                       : ~exp_diff[`FP_EXP_WIDTH-1:0] + 1'b1;

    always_ff @(posedge clk_in)
    begin
        if (accept)
        begin
            mag_0_buf      <= extend_magnitude(operand_0_class, operand_0_fraction);
            mag_1_buf      <= extend_magnitude(operand_1_class, operand_1_fraction);
            sign_0_buf     <= operand_0_sign;
            sign_1_buf     <= operand_1_sign ^ (op_mode == op_sub);
            eff_sub_buf    <= operand_0_sign ^ operand_1_sign ^ (op_mode == op_sub);
            op0_larger_buf <= op0_larger;
            class_0_buf    <= operand_0_class;
            class_1_buf    <= operand_1_class;
            round_mode_buf <= round_mode;
            exponent_buf   <= op0_larger ? operand_0_exponent : operand_1_exponent;
            shift_len_buf  <= shift_len_next;
        end
        if (ctrl_state == state_compute)
        begin
            sum_mag_buf  <= result_mag;
            sum_sign_buf <= result_sign;
        end
    end

    always_ff @(posedge clk_in)
    begin
        if (reset_in)
        begin
            ctrl_state    <= state_reset;
            sum.sum_valid <= 1'b0;
        end
        else
        begin
            sum.sum_valid <= (ctrl_state == state_post_shift);
            case (ctrl_state)
                state_reset:      ctrl_state <= state_pre_shift;
                state_pre_shift:  ctrl_state <= accept ? state_compute : state_pre_shift;
                state_compute:    ctrl_state <= state_post_shift;
                state_post_shift: ctrl_state <= state_pre_shift;
                default:          ctrl_state <= state_reset;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Alignment and magnitude add.
    ////////////////////////////////////////////////////////////////////////////

    always_comb
    begin
        big_mag    = op0_larger_buf ? mag_0_buf : mag_1_buf;
        small_mag  = op0_larger_buf ? mag_1_buf : mag_0_buf;
        big_sign   = op0_larger_buf ? sign_0_buf : sign_1_buf;
        small_sign = op0_larger_buf ? sign_1_buf : sign_0_buf;

        // Bits shifted out below the guard bits fold into sticky.
        aligned_mag    = small_mag >> shift_len_buf;
        aligned_mag[0] = aligned_mag[0] | (|(small_mag & ~({EXT_WIDTH{1'b1}} << shift_len_buf)));

        if (!eff_sub_buf)
        begin
            result_mag  = big_mag + aligned_mag;
            result_sign = big_sign;
        end
        else if (big_mag >= aligned_mag)
        begin
            result_mag  = big_mag - aligned_mag;
            result_sign = big_sign;
        end
        else
        begin
            result_mag  = aligned_mag - big_mag;    // Equal exponents only.
            result_sign = small_sign;
        end

        if (result_mag == '0)
            result_sign = eff_sub_buf ? 1'b0 : big_sign;
    end

    always_comb
    begin
        sum.special  = class_normal;
        sum.sum_sign = sum_sign_buf;
        if (class_0_buf == class_nan || class_1_buf == class_nan ||
            (class_0_buf == class_inf && class_1_buf == class_inf && eff_sub_buf))
        begin
            sum.special  = class_nan;
            sum.sum_sign = 1'b0;
        end
        else if (class_0_buf == class_inf)
        begin
            sum.special  = class_inf;
            sum.sum_sign = sign_0_buf;
        end
        else if (class_1_buf == class_inf)
        begin
            sum.special  = class_inf;
            sum.sum_sign = sign_1_buf;
        end
    end

    assign sum.sum_exponent  = exponent_buf;
    assign sum.sum_magnitude = sum_mag_buf;
    assign sum.round_mode    = round_mode_buf;

endmodule

// File: rtl/float_point_classify.sv
`timescale 1ns/1ps
`include "fp_defines.svh"

module float_point_classify
(
    input  logic [`FP_EXP_WIDTH-1:0]    exponent,
    input  logic [`FP_FRAC_WIDTH-1:0]   fraction,
    output fp_pkg::fp_class_t           fp_class
);
    import fp_pkg::*;

    always_comb
    begin
        if (exponent == '0)
        begin
            fp_class = class_zero;  // Denormals are flushed here.
        end
        else if (exponent == '1)
        begin
            fp_class = (fraction == '0) ? class_inf : class_nan;
        end
        else
        begin
            fp_class = class_normal;
        end
    end

endmodule

// File: rtl/fp_sum_if.sv
`timescale 1ns/1ps
`include "fp_defines.svh"

interface fp_sum_if;
    import fp_pkg::*;

    localparam int EXT_WIDTH = `FP_FRAC_WIDTH + `FP_GUARD_BITS + 2;

    logic                       sum_valid;      // One cycle per result.
    logic                       sum_sign;
    logic [`FP_EXP_WIDTH-1:0]   sum_exponent;   // Exponent of the larger operand.
    logic [EXT_WIDTH-1:0]       sum_magnitude;  // Carry on top, sticky in bit 0.
    round_mode_t                round_mode;
    fp_class_t                  special;        // Normal means the magnitude is used.

    modport core
    (
        output sum_valid, sum_sign, sum_exponent, sum_magnitude, round_mode, special
    );

    modport norm
    (
        input sum_valid, sum_sign, sum_exponent, sum_magnitude, round_mode, special
    );

endinterface

// File: rtl/fp_pkg.sv
package fp_pkg;

    typedef enum logic [1:0]
    {
        state_reset,
        state_pre_shift,
        state_compute,
        state_post_shift
    } ctrl_state_t;

    typedef enum logic [1:0]
    {
        class_zero,
        class_normal,
        class_inf,
        class_nan
    } fp_class_t;

    typedef enum logic {op_add, op_sub} op_mode_t;

    typedef enum logic {round_chop, round_nearest_even} round_mode_t;

endpackage

// File: rtl/fp_defines.svh
`ifndef FP_DEFINES_SVH
`define FP_DEFINES_SVH

////////////////////////////////////////////////////////////////////////////
// Single precision field widths.
////////////////////////////////////////////////////////////////////////////

`define FP_EXP_WIDTH    8
`define FP_FRAC_WIDTH   23
`define FP_EXP_BIAS     127

// Guard, round and sticky bits kept below the fraction.
`define FP_GUARD_BITS   3

`endif
